/* src/nhi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, APB link structs, lane structs and enums
// for the NIC subsystem interconnect
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package nhi_pkg;

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned NumTargets = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Requester side of an APB link
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  // Completer side of an APB link
  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // Start inclusive, end exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } addr_rule_t;

  // Lane index equals the target encoding
  typedef enum logic [1:0] {
    TGT_HND     = 2'd0,
    TGT_PKT     = 2'd1,
    TGT_CLUSTER = 2'd2,
    TGT_NONE    = 2'd3
  } target_e;

  // Initiator port to target port, held until done
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } lane_req_t;

  // Target port back to initiator port, done is a single cycle pulse
  typedef struct packed {
    logic  done;
    data_t rdata;
    logic  err;
  } lane_rsp_t;

  typedef enum logic [1:0] {
    TP_IDLE   = 2'd0,
    TP_SETUP  = 2'd1,
    TP_ACCESS = 2'd2
  } tport_state_e;

endpackage

`default_nettype wire

/* src/nhi_initiator_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// APB completer for one initiator. Decodes the address against
// the run-time rules and steers the access phase onto one lane
// Misses are answered here with a decode error
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module nhi_initiator_port (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  nhi_pkg::apb_req_t                               apb_req_i,
  output nhi_pkg::apb_rsp_t                               apb_rsp_o,
  input  nhi_pkg::addr_rule_t [nhi_pkg::NumTargets-1:0]   rules_i,
  output nhi_pkg::lane_req_t  [nhi_pkg::NumTargets-1:0]   lane_req_o,
  input  nhi_pkg::lane_rsp_t  [nhi_pkg::NumTargets-1:0]   lane_rsp_i
);

  nhi_pkg::target_e               sel_tgt;
  logic                           access;
  logic [nhi_pkg::NumTargets-1:0] rule_hit;
  logic [nhi_pkg::NumTargets-1:0] lane_valid;

  // Only the access phase is forwarded, setup stays local
  assign access = apb_req_i.psel & apb_req_i.penable;

  // Address decode
  always_comb begin
    sel_tgt = nhi_pkg::TGT_NONE;
    for (int unsigned t = 0; t < nhi_pkg::NumTargets; t++) begin
      rule_hit[t] = (apb_req_i.paddr >= rules_i[t].start_addr) &&
                    (apb_req_i.paddr <  rules_i[t].end_addr);
      if (rule_hit[t]) begin
        sel_tgt = nhi_pkg::target_e'(t);
      end
    end
  end

  // Request fields go to every lane, valid only to the decoded one
  always_comb begin
    for (int unsigned t = 0; t < nhi_pkg::NumTargets; t++) begin
      lane_valid[t]       = access && (sel_tgt == nhi_pkg::target_e'(t));
      lane_req_o[t].valid = lane_valid[t];
      lane_req_o[t].write = apb_req_i.pwrite;
      lane_req_o[t].addr  = apb_req_i.paddr;
      lane_req_o[t].wdata = apb_req_i.pwdata;
    end
  end

  // Response mux
  always_comb begin
    apb_rsp_o = '0;
    if (access && (sel_tgt == nhi_pkg::TGT_NONE)) begin
      // Decode error, completes in the access cycle with zero data
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = 1'b1;
    end else begin
      for (int unsigned t = 0; t < nhi_pkg::NumTargets; t++) begin
        if (lane_valid[t]) begin
          apb_rsp_o.pready  = lane_rsp_i[t].done;
          apb_rsp_o.prdata  = lane_rsp_i[t].rdata;
          apb_rsp_o.pslverr = lane_rsp_i[t].err;
        end
      end
    end
  end

  // Rules must not overlap, so a request never matches two targets
  a_one_lane : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    access |-> $onehot0(rule_hit)
  ) else $error("address matches more than one rule");

  // The requester keeps the transfer steady while a target works on it
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (|lane_valid && !apb_rsp_o.pready) |=>
      apb_req_i.psel && apb_req_i.penable &&
      $stable({apb_req_i.pwrite, apb_req_i.paddr, apb_req_i.pwdata})
  ) else $error("initiator changed a pending request");

endmodule

`default_nettype wire

/* src/nhi_rr_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for one shared target
// Grant is combinational, pointer moves on advance_i
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module nhi_rr_arbiter #(
  parameter int unsigned NumInitiators = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [NumInitiators-1:0] req_i,
  input  logic                     advance_i,
  output logic [NumInitiators-1:0] grant_o
);

  localparam int unsigned IdxWidth = (NumInitiators > 1) ? $clog2(NumInitiators) : 1;

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] grant_idx;

  // Scan from the far end back towards the pointer,
  // so the closest requester at or after it wins
  always_comb begin
    grant_o   = '0;
    grant_idx = ptr_q;
    for (int unsigned k = NumInitiators; k > 0; k--) begin
      if (req_i[(ptr_q + k - 1) % NumInitiators]) begin
        grant_idx = IdxWidth'((ptr_q + k - 1) % NumInitiators);
      end
    end
    if (|req_i) begin
      grant_o[grant_idx] = 1'b1;
    end
  end

  // Priority pointer, starts at initiator 0
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i && |req_i) begin
      ptr_q <= IdxWidth'((grant_idx + 1) % NumInitiators);
    end
  end

  // Advance only ever follows a granted transfer
  a_advance_granted : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    advance_i |-> |grant_o
  ) else $error("arbiter advanced without a grant");

endmodule

`default_nettype wire

/* src/nhi_target_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// APB requester for one shared target. Arbitrates the lanes,
// runs setup and access, returns the response to the winner
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module nhi_target_port #(
  parameter int unsigned NumInitiators = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  nhi_pkg::lane_req_t [NumInitiators-1:0] lane_req_i,
  output nhi_pkg::lane_rsp_t [NumInitiators-1:0] lane_rsp_o,
  output nhi_pkg::apb_req_t                      apb_req_o,
  input  nhi_pkg::apb_rsp_t                      apb_rsp_i
);

  nhi_pkg::tport_state_e    state_q;
  logic [NumInitiators-1:0] grant_q;
  logic [NumInitiators-1:0] lane_valid;
  logic [NumInitiators-1:0] arb_req;
  logic [NumInitiators-1:0] arb_grant;
  logic                     xfer_done;
  nhi_pkg::lane_req_t       sel_req;

  always_comb begin
    for (int unsigned i = 0; i < NumInitiators; i++) begin
      lane_valid[i] = lane_req_i[i].valid;
    end
  end

  // While busy the arbiter only sees the owner, so advance
  // steps past the lane that is being served
  assign arb_req   = (state_q == nhi_pkg::TP_IDLE) ? lane_valid : grant_q;
  assign xfer_done = (state_q == nhi_pkg::TP_ACCESS) && apb_rsp_i.pready;

  nhi_rr_arbiter #(
    .NumInitiators (NumInitiators)
  ) i_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (arb_req),
    .advance_i (xfer_done),
    .grant_o   (arb_grant)
  );

  // Setup and access FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= nhi_pkg::TP_IDLE;
      grant_q <= '0;
    end else begin
      case (state_q)
        nhi_pkg::TP_IDLE: begin
          if (|lane_valid) begin
            grant_q <= arb_grant;
            state_q <= nhi_pkg::TP_SETUP;
          end
        end
        nhi_pkg::TP_SETUP: begin
          state_q <= nhi_pkg::TP_ACCESS;
        end
        nhi_pkg::TP_ACCESS: begin
          if (apb_rsp_i.pready) begin
            grant_q <= '0;
            state_q <= nhi_pkg::TP_IDLE;
          end
        end
        default: begin
          grant_q <= '0;
          state_q <= nhi_pkg::TP_IDLE;
        end
      endcase
    end
  end

  // Fields of the owning lane, held there until done
  always_comb begin
    sel_req = '0;
    for (int unsigned i = 0; i < NumInitiators; i++) begin
      if (grant_q[i]) begin
        sel_req = lane_req_i[i];
      end
    end
  end

  always_comb begin
    apb_req_o.psel    = (state_q != nhi_pkg::TP_IDLE);
    apb_req_o.penable = (state_q == nhi_pkg::TP_ACCESS);
    apb_req_o.pwrite  = sel_req.write;
    apb_req_o.paddr   = sel_req.addr;
    apb_req_o.pwdata  = sel_req.wdata;
  end

  // Done pulses on the owning lane only
  always_comb begin
    lane_rsp_o = '0;
    for (int unsigned i = 0; i < NumInitiators; i++) begin
      if (grant_q[i]) begin
        lane_rsp_o[i].done  = xfer_done;
        lane_rsp_o[i].rdata = apb_rsp_i.prdata;
        lane_rsp_o[i].err   = apb_rsp_i.pslverr;
      end
    end
  end

  // Holds across the lane from the initiator side as well
  a_apb_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (apb_req_o.psel && !(apb_req_o.penable && apb_rsp_i.pready)) |=>
      apb_req_o.psel &&
      $stable({apb_req_o.pwrite, apb_req_o.paddr, apb_req_o.pwdata})
  ) else $error("target request changed before pready");

endmodule

`default_nettype wire

/* src/nhi_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Interconnect top: NIC outbound and DMA share handler L2,
// packet L2 and cluster TCDM over APB, map set at run time
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module nhi_xbar #(
  parameter int unsigned NumInitiators = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  nhi_pkg::addr_rule_t hnd_rule_i,
  input  nhi_pkg::addr_rule_t pkt_rule_i,
  input  nhi_pkg::addr_rule_t cluster_rule_i,

  // NIC outbound engine
  input  nhi_pkg::apb_req_t   no_req_i,
  output nhi_pkg::apb_rsp_t   no_rsp_o,

  // Off-cluster DMA
  input  nhi_pkg::apb_req_t   edma_req_i,
  output nhi_pkg::apb_rsp_t   edma_rsp_o,

  // Handler L2
  output nhi_pkg::apb_req_t   hnd_req_o,
  input  nhi_pkg::apb_rsp_t   hnd_rsp_i,

  // Packet L2
  output nhi_pkg::apb_req_t   pkt_req_o,
  input  nhi_pkg::apb_rsp_t   pkt_rsp_i,

  // Cluster TCDM
  output nhi_pkg::apb_req_t   cluster_req_o,
  input  nhi_pkg::apb_rsp_t   cluster_rsp_i
);

  nhi_pkg::addr_rule_t [nhi_pkg::NumTargets-1:0] rules;

  nhi_pkg::apb_req_t [NumInitiators-1:0]       ini_apb_req;
  nhi_pkg::apb_rsp_t [NumInitiators-1:0]       ini_apb_rsp;
  nhi_pkg::apb_req_t [nhi_pkg::NumTargets-1:0] tgt_apb_req;
  nhi_pkg::apb_rsp_t [nhi_pkg::NumTargets-1:0] tgt_apb_rsp;

  // Lanes seen from the initiator side, [initiator][target]
  nhi_pkg::lane_req_t [NumInitiators-1:0][nhi_pkg::NumTargets-1:0] ini_lane_req;
  nhi_pkg::lane_rsp_t [NumInitiators-1:0][nhi_pkg::NumTargets-1:0] ini_lane_rsp;
  // Same lanes seen from the target side, [target][initiator]
  nhi_pkg::lane_req_t [nhi_pkg::NumTargets-1:0][NumInitiators-1:0] tgt_lane_req;
  nhi_pkg::lane_rsp_t [nhi_pkg::NumTargets-1:0][NumInitiators-1:0] tgt_lane_rsp;

  assign rules[nhi_pkg::TGT_HND]     = hnd_rule_i;
  assign rules[nhi_pkg::TGT_PKT]     = pkt_rule_i;
  assign rules[nhi_pkg::TGT_CLUSTER] = cluster_rule_i;

  // Initiator 0 is the NIC outbound engine, 1 the DMA
  assign ini_apb_req[0] = no_req_i;
  assign ini_apb_req[1] = edma_req_i;
  assign no_rsp_o       = ini_apb_rsp[0];
  assign edma_rsp_o     = ini_apb_rsp[1];

  assign hnd_req_o     = tgt_apb_req[nhi_pkg::TGT_HND];
  assign pkt_req_o     = tgt_apb_req[nhi_pkg::TGT_PKT];
  assign cluster_req_o = tgt_apb_req[nhi_pkg::TGT_CLUSTER];

  assign tgt_apb_rsp[nhi_pkg::TGT_HND]     = hnd_rsp_i;
  assign tgt_apb_rsp[nhi_pkg::TGT_PKT]     = pkt_rsp_i;
  assign tgt_apb_rsp[nhi_pkg::TGT_CLUSTER] = cluster_rsp_i;

  for (genvar i = 0; i < NumInitiators; i++) begin : g_ini
    nhi_initiator_port i_ini_port (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .apb_req_i  (ini_apb_req[i]),
      .apb_rsp_o  (ini_apb_rsp[i]),
      .rules_i    (rules),
      .lane_req_o (ini_lane_req[i]),
      .lane_rsp_i (ini_lane_rsp[i])
    );

    // Transpose
    for (genvar t = 0; t < nhi_pkg::NumTargets; t++) begin : g_lane
      assign tgt_lane_req[t][i] = ini_lane_req[i][t];
      assign ini_lane_rsp[i][t] = tgt_lane_rsp[t][i];
    end
  end

  for (genvar t = 0; t < nhi_pkg::NumTargets; t++) begin : g_tgt
    nhi_target_port #(
      .NumInitiators (NumInitiators)
    ) i_tgt_port (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .lane_req_i (tgt_lane_req[t]),
      .lane_rsp_o (tgt_lane_rsp[t]),
      .apb_req_o  (tgt_apb_req[t]),
      .apb_rsp_i  (tgt_apb_rsp[t])
    );
  end

endmodule

`default_nettype wire

/* tb/nhi_target_model.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Behavioral APB memory for the testbench, 16 words,
// random wait states and a log of accepted writes
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module nhi_target_model #(
  parameter int unsigned Index = 0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nhi_pkg::apb_req_t req_i,
  output nhi_pkg::apb_rsp_t rsp_o
);

  nhi_pkg::data_t mem    [16];
  nhi_pkg::data_t wr_log [64];
  int unsigned    wr_cnt;
  int unsigned    sel_cnt;
  logic [1:0]     wait_q;
  logic [3:0]     widx;
  integer         seed;

  initial seed = 32'h1ef7 + Index;

  // Word address modulo 16
  assign widx = req_i.paddr[5:2];

  always_comb begin
    rsp_o = '0;
    if (req_i.psel && req_i.penable && (wait_q == 2'd0)) begin
      rsp_o.pready = 1'b1;
      rsp_o.prdata = req_i.pwrite ? '0 : mem[widx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q  <= 2'd0;
      wr_cnt  <= 0;
      sel_cnt <= 0;
    end else begin
      if (req_i.psel) begin
        sel_cnt <= sel_cnt + 1;
      end
      // 0 to 3 wait states, drawn in setup
      if (req_i.psel && !req_i.penable) begin
        wait_q <= 2'($random(seed));
      end else if (req_i.psel && (wait_q != 2'd0)) begin
        wait_q <= wait_q - 2'd1;
      end
      if (rsp_o.pready && req_i.pwrite) begin
        mem[widx] <= req_i.pwdata;
        if (wr_cnt < 64) begin
          wr_log[wr_cnt] <= req_i.pwdata;
          wr_cnt         <= wr_cnt + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_nhi_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the interconnect: two APB initiators, three
// memory models, a stimulus table and concurrent phases
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_nhi_xbar;

  localparam int ClkPeriod     = 100;
  localparam int ResetCycles   = 16;
  localparam int TimeoutCycles = 200;
  localparam int NumRows       = 20;

  // One transfer with its expected response
  typedef struct packed {
    logic           ini;
    logic           write;
    nhi_pkg::addr_t addr;
    nhi_pkg::data_t wdata;
    nhi_pkg::data_t rdata;
    logic           err;
  } row_t;

  logic                clk;
  logic                rst_n;
  nhi_pkg::addr_rule_t hnd_rule;
  nhi_pkg::addr_rule_t pkt_rule;
  nhi_pkg::addr_rule_t cluster_rule;
  nhi_pkg::apb_req_t   no_req;
  nhi_pkg::apb_rsp_t   no_rsp;
  nhi_pkg::apb_req_t   edma_req;
  nhi_pkg::apb_rsp_t   edma_rsp;
  nhi_pkg::apb_req_t   hnd_req;
  nhi_pkg::apb_rsp_t   hnd_rsp;
  nhi_pkg::apb_req_t   pkt_req;
  nhi_pkg::apb_rsp_t   pkt_rsp;
  nhi_pkg::apb_req_t   cluster_req;
  nhi_pkg::apb_rsp_t   cluster_rsp;
  row_t                rows [NumRows];
  int                  errors;
  int                  timeouts;

  assign hnd_rule     = '{start_addr: 32'h1000, end_addr: 32'h1040};
  assign pkt_rule     = '{start_addr: 32'h2000, end_addr: 32'h2040};
  assign cluster_rule = '{start_addr: 32'h3000, end_addr: 32'h3040};

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  nhi_xbar #(
    .NumInitiators (2)
  ) uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .hnd_rule_i     (hnd_rule),
    .pkt_rule_i     (pkt_rule),
    .cluster_rule_i (cluster_rule),
    .no_req_i       (no_req),
    .no_rsp_o       (no_rsp),
    .edma_req_i     (edma_req),
    .edma_rsp_o     (edma_rsp),
    .hnd_req_o      (hnd_req),
    .hnd_rsp_i      (hnd_rsp),
    .pkt_req_o      (pkt_req),
    .pkt_rsp_i      (pkt_rsp),
    .cluster_req_o  (cluster_req),
    .cluster_rsp_i  (cluster_rsp)
  );

  nhi_target_model #(.Index(0)) m_hnd (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (hnd_req), .rsp_o (hnd_rsp)
  );
  nhi_target_model #(.Index(1)) m_pkt (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (pkt_req), .rsp_o (pkt_rsp)
  );
  nhi_target_model #(.Index(2)) m_cluster (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (cluster_req), .rsp_o (cluster_rsp)
  );

  task automatic check_val(input string name, input nhi_pkg::data_t exp,
                           input nhi_pkg::data_t act);
    assert (act === exp) else begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  function automatic string port_name(input logic ini);
    return ini ? "edma_rsp_o" : "no_rsp_o";
  endfunction

  function automatic nhi_pkg::apb_rsp_t read_rsp(input logic ini);
    return ini ? edma_rsp : no_rsp;
  endfunction

  function automatic nhi_pkg::data_t sel_total();
    return nhi_pkg::data_t'(m_hnd.sel_cnt + m_pkt.sel_cnt + m_cluster.sel_cnt);
  endfunction

  task automatic drive_req(input logic ini, input nhi_pkg::apb_req_t req);
    if (ini) begin
      edma_req = req;
    end else begin
      no_req = req;
    end
  endtask

  // Called at a falling edge, returns at the falling edge after completion
  task automatic apb_xfer(input logic ini, input logic write, input nhi_pkg::addr_t addr,
                          input nhi_pkg::data_t wdata, output nhi_pkg::data_t rdata,
                          output logic err);
    nhi_pkg::apb_req_t req;
    nhi_pkg::apb_rsp_t rsp;
    int                cycles;
    req        = '0;
    req.psel   = 1'b1;
    req.pwrite = write;
    req.paddr  = addr;
    req.pwdata = wdata;
    drive_req(ini, req);
    @(negedge clk);
    req.penable = 1'b1;
    drive_req(ini, req);
    cycles = 0;
    // Sample a quarter period after the drive, well away from both edges
    #(ClkPeriod / 4);
    rsp = read_rsp(ini);
    while (!rsp.pready && (cycles < TimeoutCycles)) begin
      @(negedge clk);
      #(ClkPeriod / 4);
      rsp = read_rsp(ini);
      cycles++;
    end
    if (!rsp.pready) begin
      timeouts++;
      $display("Initiator %0d transfer timed out at address %h", ini, addr);
    end
    rdata = rsp.prdata;
    err   = rsp.pslverr;
    @(negedge clk);
    drive_req(ini, '0);
  endtask

  task automatic write_expect(input logic ini, input nhi_pkg::addr_t addr,
                              input nhi_pkg::data_t data);
    nhi_pkg::data_t rdata;
    logic           err;
    apb_xfer(ini, 1'b1, addr, data, rdata, err);
    check_val($sformatf("%s.pslverr", port_name(ini)), '0, nhi_pkg::data_t'(err));
  endtask

  task automatic read_expect(input logic ini, input nhi_pkg::addr_t addr,
                             input nhi_pkg::data_t exp);
    nhi_pkg::data_t rdata;
    logic           err;
    apb_xfer(ini, 1'b0, addr, '0, rdata, err);
    check_val($sformatf("%s.prdata", port_name(ini)), exp, rdata);
    check_val($sformatf("%s.pslverr", port_name(ini)), '0, nhi_pkg::data_t'(err));
  endtask

  task automatic write_burst(input logic ini, input nhi_pkg::addr_t base,
                             input nhi_pkg::data_t data_base);
    for (int k = 0; k < 4; k++) begin
      write_expect(ini, base + 4 * k, data_base + k);
    end
  endtask

  // Both initiators fought over the packet memory from the reset pointer
  task automatic check_arbitration_log();
    check_val("pkt write count", 32'd8, nhi_pkg::data_t'(m_pkt.wr_cnt));
    for (int k = 0; k < 4; k++) begin
      check_val($sformatf("pkt wr_log[%0d]", 2 * k), 32'hA000_0000 + k, m_pkt.wr_log[2 * k]);
      check_val($sformatf("pkt wr_log[%0d]", 2 * k + 1), 32'hB000_0000 + k,
                m_pkt.wr_log[2 * k + 1]);
    end
  endtask

  task automatic run_row(input int idx);
    nhi_pkg::data_t rdata;
    logic           err;
    nhi_pkg::data_t sel_before;
    sel_before = sel_total();
    apb_xfer(rows[idx].ini, rows[idx].write, rows[idx].addr, rows[idx].wdata, rdata, err);
    check_val($sformatf("%s.pslverr", port_name(rows[idx].ini)),
              nhi_pkg::data_t'(rows[idx].err), nhi_pkg::data_t'(err));
    if (!rows[idx].write || rows[idx].err) begin
      check_val($sformatf("%s.prdata", port_name(rows[idx].ini)), rows[idx].rdata, rdata);
    end
    if (rows[idx].err) begin
      // A target would show psel one cycle after the access phase
      @(negedge clk);
      check_val("target psel cycles", sel_before, sel_total());
    end
  endtask

  task automatic load_table();
    // ini, write, addr, wdata, rdata, err
    rows[0]  = '{1'b0, 1'b1, 32'h1000, 32'h4e44_0000, 32'h0, 1'b0};
    rows[1]  = '{1'b0, 1'b0, 32'h1000, 32'h0, 32'h4e44_0000, 1'b0};
    rows[2]  = '{1'b1, 1'b0, 32'h1000, 32'h0, 32'h4e44_0000, 1'b0};
    rows[3]  = '{1'b1, 1'b1, 32'h1004, 32'h4e44_0004, 32'h0, 1'b0};
    rows[4]  = '{1'b1, 1'b0, 32'h1004, 32'h0, 32'h4e44_0004, 1'b0};
    rows[5]  = '{1'b0, 1'b0, 32'h1004, 32'h0, 32'h4e44_0004, 1'b0};
    rows[6]  = '{1'b0, 1'b1, 32'h2000, 32'h504b_0000, 32'h0, 1'b0};
    rows[7]  = '{1'b0, 1'b0, 32'h2000, 32'h0, 32'h504b_0000, 1'b0};
    rows[8]  = '{1'b1, 1'b0, 32'h2000, 32'h0, 32'h504b_0000, 1'b0};
    rows[9]  = '{1'b1, 1'b1, 32'h2004, 32'h504b_0004, 32'h0, 1'b0};
    rows[10] = '{1'b1, 1'b0, 32'h2004, 32'h0, 32'h504b_0004, 1'b0};
    rows[11] = '{1'b0, 1'b0, 32'h2004, 32'h0, 32'h504b_0004, 1'b0};
    rows[12] = '{1'b0, 1'b1, 32'h3000, 32'h434c_0000, 32'h0, 1'b0};
    rows[13] = '{1'b0, 1'b0, 32'h3000, 32'h0, 32'h434c_0000, 1'b0};
    rows[14] = '{1'b1, 1'b0, 32'h3000, 32'h0, 32'h434c_0000, 1'b0};
    rows[15] = '{1'b1, 1'b1, 32'h3004, 32'h434c_0004, 32'h0, 1'b0};
    rows[16] = '{1'b1, 1'b0, 32'h3004, 32'h0, 32'h434c_0004, 1'b0};
    rows[17] = '{1'b0, 1'b0, 32'h3004, 32'h0, 32'h434c_0004, 1'b0};
    // Misses, the second one just past the handler end
    rows[18] = '{1'b0, 1'b0, 32'h5000, 32'h0, 32'h0, 1'b1};
    rows[19] = '{1'b1, 1'b1, 32'h1040, 32'hdead_beef, 32'h0, 1'b1};
  endtask

  initial begin
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    no_req   = '0;
    edma_req = '0;
    load_table();
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle after reset
    check_val("hnd_req_o.psel", '0, nhi_pkg::data_t'(hnd_req.psel));
    check_val("pkt_req_o.psel", '0, nhi_pkg::data_t'(pkt_req.psel));
    check_val("cluster_req_o.psel", '0, nhi_pkg::data_t'(cluster_req.psel));
    check_val("no_rsp_o.pready", '0, nhi_pkg::data_t'(no_rsp.pready));
    check_val("edma_rsp_o.pready", '0, nhi_pkg::data_t'(edma_rsp.pready));

    // Round robin on the packet memory, pointer still at its reset value
    fork
      write_burst(1'b0, 32'h2020, 32'hA000_0000);
      write_burst(1'b1, 32'h2030, 32'hB000_0000);
    join
    check_arbitration_log();

    for (int i = 0; i < NumRows; i++) begin
      run_row(i);
    end

    // Different targets at once, then one shared target at once
    fork
      write_expect(1'b0, 32'h1010, 32'h6e6f_1010);
      write_expect(1'b1, 32'h3014, 32'h6564_3014);
    join
    fork
      write_expect(1'b0, 32'h2010, 32'h6e6f_2010);
      write_expect(1'b1, 32'h2014, 32'h6564_2014);
    join
    read_expect(1'b1, 32'h1010, 32'h6e6f_1010);
    read_expect(1'b1, 32'h2010, 32'h6e6f_2010);
    read_expect(1'b0, 32'h2014, 32'h6564_2014);
    read_expect(1'b0, 32'h3014, 32'h6564_3014);

    $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
src/nhi_pkg.sv
src/nhi_initiator_port.sv
src/nhi_rr_arbiter.sv
src/nhi_target_port.sv
src/nhi_xbar.sv
tb/nhi_target_model.sv
tb/tb_nhi_xbar.sv
